//--- verilog.f
+incdir+design
design/trig_pkg.sv
design/variable_delay.sv
design/trigger_detect.sv
design/header_footer_framer.sv
design/threshold_fifo.sv
design/trig_buffer.sv
design/trig_channel_top.sv
tb/trig_channel_checker.sv
tb/trig_channel_tb.sv

//--- tb/trig_channel_tb.sv
`include "trig_cfg.svh"

module trig_channel_tb;

  localparam int num_phases = 5;
  localparam int phase_cycles = 400;
  localparam int active_cycles = 300;
  localparam int limit_time = (num_phases * phase_cycles + 200) * 4;

  logic                                  clk = 1'b0;
  logic                                  reset;
  logic [`TRIG_WIDTH-1:0]                din;
  logic [`TRIG_ADC_BITS:0]               threshold;
  logic [`TRIG_ADC_BITS-1:0]             baseline;
  logic [$clog2(`TRIG_MAX_BACK+1)-1:0]   back_len;
  logic                                  read_en;
  logic [`TRIG_TS_BITS-1:0]              time_stamp;
  trig_pkg::fifo_word_t                  dout;
  logic                                  read_valid;
  logic                                  write_ready;
  logic                                  almost_full;
  logic [15:0]                           dropped;
  logic [31:0]                           lfsr = 32'hf38f_cf3d;
  int                                    cyc;
  int                                    read_mode [num_phases] = '{1, 2, 0, 1, 2};

  always #2 clk = ~clk;

  trig_channel_top DUT (
    .clk         (clk),
    .reset       (reset),
    .din         (din),
    .threshold   (threshold),
    .baseline    (baseline),
    .back_len    (back_len),
    .read_en     (read_en),
    .time_stamp  (time_stamp),
    .dout        (dout),
    .read_valid  (read_valid),
    .write_ready (write_ready),
    .almost_full (almost_full),
    .dropped     (dropped)
  );

  bind trig_channel_top trig_channel_checker chk (
    .clk         (clk),
    .reset       (reset),
    .din         (din),
    .threshold   (threshold),
    .baseline    (baseline),
    .back_len    (back_len),
    .read_en     (read_en),
    .fifo_we     (buffer.fifo_we),
    .time_stamp  (time_stamp),
    .dout        (dout),
    .read_valid  (read_valid),
    .write_ready (write_ready),
    .almost_full (almost_full),
    .dropped     (dropped)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // Cycle tag in lanes 1 to 7, lane 0 quiet or pulsed
  function automatic logic [`TRIG_WIDTH-1:0] sample_word(input int tag, input logic pulse);
    logic [`TRIG_WIDTH-1:0] w;
    for (int i = 1; i < `TRIG_LANES; i++)
      w[i*16 +: 16] = 16'(tag);
    w[15:0] = pulse ? 16'd4000 : 16'd300;
    return w;
  endfunction

  task automatic next_cycle(input logic pulse);
    @(posedge clk);
    #1;
    cyc = cyc + 1;
    din = sample_word(cyc, pulse);
  endtask

  // Mode 0 never reads, 1 reads at random, 2 always reads
  task automatic run_phase(input int mode);
    logic [31:0] r;
    int          gap;
    take_bits(6, r);
    back_len = 6'(r % (`TRIG_MAX_BACK + 1));
    take_bits(8, r);
    baseline = 12'(100 + int'(r));
    take_bits(9, r);
    threshold = 13'(2600 + int'(r));       // Pulses stay above, tags and quiet below
    gap = 45;                              // Lets the delay line refill
    for (int n = 0; n < active_cycles; n++)
    begin
      next_cycle(gap == 0);
      take_bits(1, r);
      read_en = (mode == 2) || (mode == 1 && r[0]);
      if (gap == 0)
      begin
        take_bits(6, r);
        gap = 4 + int'(r);
      end
      else
        gap = gap - 1;
    end
    read_en = 1'b1;
    repeat (24) next_cycle(1'b0);          // Last frame finishes writing
    while (read_valid)
      next_cycle(1'b0);
  endtask

  initial
  begin
    reset     = 1'b1;
    din       = '0;
    threshold = 13'd3000;
    baseline  = 12'd200;
    back_len  = '0;
    read_en   = 1'b0;
    cyc       = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    din   = sample_word(0, 1'b0);          // time_stamp is 0 here
    for (int p = 0; p < num_phases; p++)
      run_phase(read_mode[p]);
    if (DUT.chk.errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    wait (DUT.chk.errors != 0);
    $display("CHECKS FAILED");
    $fatal(1, "assertion failure at time %0t", $time);
  end

  initial
  begin
    #(limit_time);
    $display("CHECKS FAILED");
    $fatal(1, "timeout after %0d time units", limit_time);
  end

endmodule

//--- tb/trig_channel_checker.sv
`include "trig_cfg.svh"

module trig_channel_checker
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`TRIG_WIDTH-1:0]                din,
  input  logic [`TRIG_ADC_BITS:0]               threshold,
  input  logic [`TRIG_ADC_BITS-1:0]             baseline,
  input  logic [$clog2(`TRIG_MAX_BACK+1)-1:0]   back_len,
  input  logic                                  read_en,
  input  logic                                  fifo_we,
  input  logic [`TRIG_TS_BITS-1:0]              time_stamp,
  input  trig_pkg::fifo_word_t                  dout,
  input  logic                                  read_valid,
  input  logic                                  write_ready,
  input  logic                                  almost_full,
  input  logic [15:0]                           dropped
);

  localparam int frame_len = `TRIG_RECORD_LEN + 2;
  localparam int af_level = `TRIG_FIFO_DEPTH * `TRIG_AF_PERCENT / 100;
  localparam int lane_bits = `TRIG_WIDTH / `TRIG_LANES;

  int                      errors = 0;
  int                      occ;      // Words written minus words read
  int                      pos;      // Word index within the frame
  int                      run_len;
  int                      len_age;
  int                      cur_age;  // Cycles since back_len took its value
  logic [15:0]             hdr_tag;
  logic [15:0]             exp_tag;
  logic                    rd;
  logic                    exp_ready;
  logic                    over;
  logic                    over_q;
  logic                    trig_seen;
  logic [`TRIG_TS_BITS-1:0]                exp_stamp;
  logic [$clog2(`TRIG_MAX_BACK+1)-1:0]     len_q;
  trig_pkg::frame_tag_e    exp_kind;
  trig_pkg::frame_header_t hdr;
  trig_pkg::frame_footer_t ftr;

  assign rd       = read_en && (occ != 0);
  assign hdr      = dout.data;
  assign ftr      = dout.data;
  assign exp_tag  = hdr_tag + 16'd2 - 16'(back_len) + 16'(pos - 1);
  assign exp_kind = (pos == 0) ? trig_pkg::TAG_HEADER :
                    (pos == frame_len - 1) ? trig_pkg::TAG_FOOTER : trig_pkg::TAG_PAYLOAD;
  assign cur_age  = (back_len != len_q) ? 0 : len_age;

  // Delay line filled and room in the FIFO
  assign exp_ready = (cur_age != 0) && (cur_age >= int'(back_len)) &&
                     (occ < `TRIG_FIFO_DEPTH);

  // Any lane more than threshold above baseline
  always_comb
  begin
    over = 1'b0;
    for (int i = 0; i < `TRIG_LANES; i++)
      if (int'(din[i*lane_bits +: `TRIG_ADC_BITS]) - int'(baseline) > int'(threshold))
        over = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      occ       <= 0;
      pos       <= 0;
      run_len   <= 0;
      hdr_tag   <= '0;
      exp_stamp <= '0;
      len_age   <= 0;
      len_q     <= '0;
      over_q    <= 1'b0;
      trig_seen <= 1'b0;
    end
    else
    begin
      occ       <= occ + int'(fifo_we) - int'(rd);
      run_len   <= fifo_we ? run_len + 1 : 0;
      exp_stamp <= exp_stamp + 1'b1;
      len_age   <= cur_age + 1;
      len_q     <= back_len;
      over_q    <= over;
      trig_seen <= over && !over_q;  // Trigger pulse cycle
      if (rd)
      begin
        pos <= (pos == frame_len - 1) ? 0 : pos + 1;
        if (pos == 0)
          hdr_tag <= hdr.time_stamp[15:0];  // Cycle tag of the hit
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame shape and contents
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  frame_order: assert property (@(posedge clk) disable iff (reset)
    rd |-> dout.tag == exp_kind)
    else
    begin
      errors = errors + 1;
      $error("ERROR dout.tag %h expected %h", $sampled(dout.tag), $sampled(exp_kind));
    end

  header_id: assert property (@(posedge clk) disable iff (reset)
    rd && pos == 0 |-> hdr.channel_id == `TRIG_CHANNEL_ID)
    else
    begin
      errors = errors + 1;
      $error("ERROR header.channel_id %h expected %h", $sampled(hdr.channel_id),
             `TRIG_CHANNEL_ID);
    end

  footer_count: assert property (@(posedge clk) disable iff (reset)
    rd && pos == frame_len - 1 |-> ftr.payload_count == 8'(`TRIG_RECORD_LEN))
    else
    begin
      errors = errors + 1;
      $error("ERROR footer.payload_count %h expected %h", $sampled(ftr.payload_count),
             8'(`TRIG_RECORD_LEN));
    end

  footer_context: assert property (@(posedge clk) disable iff (reset)
    rd && pos == frame_len - 1 |-> ftr.threshold == threshold && ftr.baseline == baseline)
    else
    begin
      errors = errors + 1;
      $error("ERROR footer.threshold/baseline %h/%h expected %h/%h", $sampled(ftr.threshold),
             $sampled(ftr.baseline), $sampled(threshold), $sampled(baseline));
    end

  // Payload k holds din from hit cycle + 2 - back_len + k
  look_back: assert property (@(posedge clk) disable iff (reset)
    rd && pos != 0 && pos != frame_len - 1 |-> dout.data[31:16] == exp_tag)
    else
    begin
      errors = errors + 1;
      $error("ERROR dout.data lane 1 %h expected %h", $sampled(dout.data[31:16]),
             $sampled(exp_tag));
    end

  stamp_count: assert property (@(posedge clk) disable iff (reset)
    time_stamp == exp_stamp)
    else
    begin
      errors = errors + 1;
      $error("ERROR time_stamp %h expected %h", $sampled(time_stamp), $sampled(exp_stamp));
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FIFO flags, drop rule, reset
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  valid_flag: assert property (@(posedge clk) disable iff (reset)
    read_valid == (occ != 0))
    else
    begin
      errors = errors + 1;
      $error("ERROR read_valid %h expected %h", $sampled(read_valid), $sampled(occ != 0));
    end

  af_flag: assert property (@(posedge clk) disable iff (reset)
    almost_full == (occ >= af_level))
    else
    begin
      errors = errors + 1;
      $error("ERROR almost_full %h expected %h", $sampled(almost_full),
             $sampled(occ >= af_level));
    end

  ready_flag: assert property (@(posedge clk) disable iff (reset)
    write_ready == exp_ready)
    else
    begin
      errors = errors + 1;
      $error("ERROR write_ready %h expected %h", $sampled(write_ready), $sampled(exp_ready));
    end

  no_overflow: assert property (@(posedge clk) disable iff (reset)
    fifo_we |-> occ < `TRIG_FIFO_DEPTH)
    else
    begin
      errors = errors + 1;
      $error("Frame word written into a full FIFO");
    end

  whole_frame: assert property (@(posedge clk) disable iff (reset)
    $fell(fifo_we) |-> run_len == frame_len)
    else
    begin
      errors = errors + 1;
      $error("Frame write burst of %0d words instead of %0d", $sampled(run_len), frame_len);
    end

  drop_step: assert property (@(posedge clk) disable iff (reset)
    dropped == $past(dropped) || dropped == $past(dropped) + 16'd1)
    else
    begin
      errors = errors + 1;
      $error("ERROR dropped %h after %h", $sampled(dropped), $past(dropped));
    end

  // Trigger without room for a whole frame
  room_drop: assert property (@(posedge clk) disable iff (reset)
    trig_seen && occ > `TRIG_FIFO_DEPTH - frame_len |=> dropped == $past(dropped) + 16'd1)
    else
    begin
      errors = errors + 1;
      $error("ERROR dropped %h expected %h", $sampled(dropped), $past(dropped) + 16'd1);
    end

  after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !read_valid && !almost_full && !write_ready && dropped == '0)
    else
    begin
      errors = errors + 1;
      $error("ERROR read_valid/almost_full/write_ready/dropped %h/%h/%h/%h expected 0",
             $sampled(read_valid), $sampled(almost_full), $sampled(write_ready),
             $sampled(dropped));
    end

endmodule

//--- design/trig_channel_top.sv
`include "trig_cfg.svh"

module trig_channel_top
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`TRIG_WIDTH-1:0]                din,
  input  logic [`TRIG_ADC_BITS:0]               threshold,
  input  logic [`TRIG_ADC_BITS-1:0]             baseline,
  input  logic [$clog2(`TRIG_MAX_BACK+1)-1:0]   back_len,
  input  logic                                  read_en,
  output logic [`TRIG_TS_BITS-1:0]              time_stamp,
  output trig_pkg::fifo_word_t                  dout,
  output logic                                  read_valid,
  output logic                                  write_ready,
  output logic                                  almost_full,
  output logic [15:0]                           dropped
);

  logic                trig;
  trig_pkg::hit_info_t hit;

  trigger_detect detect (
    .clk        (clk),
    .reset      (reset),
    .din        (din),
    .threshold  (threshold),
    .baseline   (baseline),
    .time_stamp (time_stamp),
    .trig       (trig),
    .hit        (hit)
  );

  // Pre-trigger delay, framing and buffering
  trig_buffer buffer (
    .clk         (clk),
    .reset       (reset),
    .back_len    (back_len),
    .din         (din),
    .trig        (trig),
    .hit         (hit),
    .read_en     (read_en),
    .dout        (dout),
    .read_valid  (read_valid),
    .write_ready (write_ready),
    .almost_full (almost_full),
    .dropped     (dropped)
  );

endmodule

//--- design/trig_buffer.sv
`include "trig_cfg.svh"

module trig_buffer
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [$clog2(`TRIG_MAX_BACK+1)-1:0]   back_len,
  input  logic [`TRIG_WIDTH-1:0]                din,
  input  logic                                  trig,
  input  trig_pkg::hit_info_t                   hit,
  input  logic                                  read_en,
  output trig_pkg::fifo_word_t                  dout,
  output logic                                  read_valid,
  output logic                                  write_ready,
  output logic                                  almost_full,
  output logic [15:0]                           dropped
);

  logic [`TRIG_WIDTH-1:0]                 delay_dout;
  logic                                   delay_valid;
  trig_pkg::fifo_word_t                   fifo_din;
  logic                                   fifo_we;
  logic                                   full;
  logic [$clog2(`TRIG_FIFO_DEPTH+1)-1:0]  count;

  assign write_ready = delay_valid && !full;

  variable_delay #(
    .max_delay (`TRIG_MAX_BACK),
    .width     (`TRIG_WIDTH)
  ) back_delay (
    .clk      (clk),
    .reset    (reset),
    .back_len (back_len),
    .din      (din),
    .dout     (delay_dout),
    .valid    (delay_valid)
  );

  header_footer_framer framer (
    .clk        (clk),
    .reset      (reset),
    .din        (delay_dout),
    .din_valid  (delay_valid),
    .trig       (trig),
    .hit        (hit),
    .fifo_count (count),
    .dout       (fifo_din),
    .we         (fifo_we),
    .dropped    (dropped)
  );

  threshold_fifo #(
    .depth      (`TRIG_FIFO_DEPTH),
    .af_percent (`TRIG_AF_PERCENT)
  ) buff_fifo (
    .clk         (clk),
    .reset       (reset),
    .din         (fifo_din),
    .we          (fifo_we),
    .re          (read_en),
    .dout        (dout),
    .not_empty   (read_valid),
    .almost_full (almost_full),
    .full        (full),
    .count       (count)
  );

endmodule

//--- design/threshold_fifo.sv
module threshold_fifo
#(
  parameter int depth = 64,
  parameter int af_percent = 50
)
(
  input  logic                            clk,
  input  logic                            reset,
  input  trig_pkg::fifo_word_t            din,
  input  logic                            we,
  input  logic                            re,
  output trig_pkg::fifo_word_t            dout,
  output logic                            not_empty,
  output logic                            almost_full,
  output logic                            full,
  output logic [$clog2(depth+1)-1:0]      count
);

  localparam int aw = $clog2(depth);
  localparam int af_level = depth * af_percent / 100;

  trig_pkg::fifo_word_t mem [depth];
  logic [aw-1:0]        wr_ptr;
  logic [aw-1:0]        rd_ptr;
  logic                 do_write;
  logic                 do_read;

  assign do_write = we && !full;
  assign do_read  = re && not_empty;  // Read while empty is ignored

  always_ff @(posedge clk)
  begin
    if (do_write)
      mem[wr_ptr] <= din;
  end

  // Show-ahead head word
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign not_empty   = (count != '0);
  assign full        = (count == depth);
  assign almost_full = (count >= af_level);

endmodule

//--- design/header_footer_framer.sv
`include "trig_cfg.svh"

module header_footer_framer
(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [`TRIG_WIDTH-1:0]                  din,
  input  logic                                    din_valid,
  input  logic                                    trig,
  input  trig_pkg::hit_info_t                     hit,
  input  logic [$clog2(`TRIG_FIFO_DEPTH+1)-1:0]   fifo_count,
  output trig_pkg::fifo_word_t                    dout,
  output logic                                    we,
  output logic [15:0]                             dropped
);

  trig_pkg::framer_state_e state;
  trig_pkg::hit_info_t     hit_q;
  trig_pkg::frame_header_t header;
  trig_pkg::frame_footer_t footer;
  logic [7:0]              word_cnt;
  logic                    room;
  logic                    accept;

  // Whole frame must fit before it starts
  assign room   = fifo_count <= (`TRIG_FIFO_DEPTH - `TRIG_RECORD_LEN - 2);
  assign accept = trig && din_valid && room && (state == trig_pkg::ST_IDLE);

  always_comb
  begin
    header            = '0;
    header.marker     = trig_pkg::HEADER_MARKER;
    header.channel_id = `TRIG_CHANNEL_ID;
    header.time_stamp = hit.time_stamp;
    footer               = '0;
    footer.threshold     = hit_q.threshold;
    footer.baseline      = hit_q.baseline;
    footer.payload_count = word_cnt;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame FSM; state names the word currently on dout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= trig_pkg::ST_IDLE;
      word_cnt <= '0;
      dropped  <= '0;
    end
    else
    begin
      if (trig && !accept)
        dropped <= dropped + 1'b1;
      case (state)
        trig_pkg::ST_IDLE:
          if (accept)
            state <= trig_pkg::ST_HEADER;
        trig_pkg::ST_HEADER:
        begin
          state    <= trig_pkg::ST_PAYLOAD;
          word_cnt <= 8'd1;
        end
        trig_pkg::ST_PAYLOAD:
          if (word_cnt == 8'(`TRIG_RECORD_LEN))
            state <= trig_pkg::ST_FOOTER;
          else
            word_cnt <= word_cnt + 1'b1;
        default:
          state <= trig_pkg::ST_IDLE;
      endcase
    end
  end

  // Output word and latched context
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      hit_q    <= hit;
      dout.tag  <= trig_pkg::TAG_HEADER;
      dout.data <= header;
    end
    else if (state == trig_pkg::ST_HEADER ||
             (state == trig_pkg::ST_PAYLOAD && word_cnt != 8'(`TRIG_RECORD_LEN)))
    begin
      dout.tag  <= trig_pkg::TAG_PAYLOAD;
      dout.data <= din;
    end
    else if (state == trig_pkg::ST_PAYLOAD)
    begin
      dout.tag  <= trig_pkg::TAG_FOOTER;
      dout.data <= footer;
    end
  end

  assign we = (state != trig_pkg::ST_IDLE);

endmodule

//--- design/trigger_detect.sv
`include "trig_cfg.svh"

module trigger_detect
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`TRIG_WIDTH-1:0]     din,
  input  logic [`TRIG_ADC_BITS:0]    threshold,
  input  logic [`TRIG_ADC_BITS-1:0]  baseline,
  output logic [`TRIG_TS_BITS-1:0]   time_stamp,
  output logic                       trig,
  output trig_pkg::hit_info_t        hit
);

  localparam int lane_bits = `TRIG_WIDTH / `TRIG_LANES;

  logic signed [`TRIG_ADC_BITS+1:0] diff [`TRIG_LANES];
  logic                             any_over;
  logic                             over_q;

  // Sample minus baseline, signed with headroom
  always_comb
  begin
    any_over = 1'b0;
    for (int i = 0; i < `TRIG_LANES; i++)
    begin
      diff[i] = $signed({2'b00, din[i*lane_bits +: `TRIG_ADC_BITS]})
              - $signed({2'b00, baseline});
      if (diff[i] > $signed({1'b0, threshold}))
        any_over = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      time_stamp <= '0;
      over_q     <= 1'b0;
      trig       <= 1'b0;
    end
    else
    begin
      time_stamp <= time_stamp + 1'b1;
      over_q     <= any_over;
      trig       <= any_over && !over_q;  // Rising edge only
    end
  end

  // Context of the hit cycle
  always_ff @(posedge clk)
  begin
    if (any_over && !over_q)
    begin
      hit.time_stamp <= time_stamp;
      hit.threshold  <= threshold;
      hit.baseline   <= baseline;
    end
  end

endmodule

//--- design/variable_delay.sv
module variable_delay
#(
  parameter int max_delay = 40,
  parameter int width = 128
)
(
  input  logic                               clk,
  input  logic                               reset,
  input  logic [$clog2(max_delay+1)-1:0]     back_len,
  input  logic [width-1:0]                   din,
  output logic [width-1:0]                   dout,
  output logic                               valid
);

  localparam int lw = $clog2(max_delay + 1);

  logic [width-1:0] ring [max_delay];
  logic [lw-1:0]    wr_ptr;
  logic [lw-1:0]    rd_ptr;
  logic [lw-1:0]    eff_len;
  logic [lw-1:0]    last_len;
  logic [lw-1:0]    fill;
  logic [lw-1:0]    fill_next;
  logic             valid_q;

  assign eff_len = (back_len > lw'(max_delay)) ? lw'(max_delay) : back_len;

  // Wraps modulo the ring size
  assign rd_ptr = (wr_ptr >= eff_len) ? wr_ptr - eff_len
                                      : wr_ptr + lw'(max_delay) - eff_len;

  assign dout = (eff_len == '0) ? din : ring[rd_ptr];

  always_ff @(posedge clk)
  begin
    ring[wr_ptr] <= din;
  end

  always_comb
  begin
    if (back_len != last_len)
      fill_next = lw'(1);  // Restart on length change
    else if (fill == lw'(max_delay))
      fill_next = fill;
    else
      fill_next = fill + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      fill     <= '0;
      last_len <= '0;
      valid_q  <= 1'b0;
    end
    else
    begin
      wr_ptr   <= (wr_ptr == lw'(max_delay - 1)) ? '0 : wr_ptr + 1'b1;
      fill     <= fill_next;
      last_len <= back_len;
      valid_q  <= (fill_next >= eff_len);
    end
  end

  assign valid = valid_q && (back_len == last_len);

endmodule

//--- design/trig_pkg.sv
`include "trig_cfg.svh"

package trig_pkg;

  // Marker at the top of every header word
  localparam logic [15:0] HEADER_MARKER = 16'hcafe;

  typedef enum logic [1:0]
  {
    TAG_HEADER,
    TAG_PAYLOAD,
    TAG_FOOTER
  } frame_tag_e;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD,
    ST_FOOTER
  } framer_state_e;

  typedef struct packed
  {
    frame_tag_e              tag;
    logic [`TRIG_WIDTH-1:0]  data;
  } fifo_word_t;

  typedef struct packed
  {
    logic [15:0]               marker;
    logic [7:0]                channel_id;
    logic [`TRIG_TS_BITS-1:0]  time_stamp;
    logic [`TRIG_WIDTH-16-8-`TRIG_TS_BITS-1:0] pad;
  } frame_header_t;

  typedef struct packed
  {
    logic [`TRIG_ADC_BITS:0]    threshold;
    logic [`TRIG_ADC_BITS-1:0]  baseline;
    logic [7:0]                 payload_count;
    logic [`TRIG_WIDTH-2*`TRIG_ADC_BITS-1-8-1:0] pad;
  } frame_footer_t;

  // Context captured with each trigger
  typedef struct packed
  {
    logic [`TRIG_TS_BITS-1:0]   time_stamp;
    logic [`TRIG_ADC_BITS:0]    threshold;
    logic [`TRIG_ADC_BITS-1:0]  baseline;
  } hit_info_t;

endpackage

//--- design/trig_cfg.svh
`ifndef TRIG_CFG_SVH
`define TRIG_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample word layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TRIG_WIDTH       128
`define TRIG_LANES       8   // 16-bit slot per lane
`define TRIG_ADC_BITS    12
`define TRIG_TS_BITS     49

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Record and buffer sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define TRIG_RECORD_LEN  16  // Payload words per frame
`define TRIG_MAX_BACK    40
`define TRIG_FIFO_DEPTH  64
`define TRIG_AF_PERCENT  50

// Channel identity
`define TRIG_CHANNEL_ID  8'd3

`endif
